// File: rtl/eccMem_macros.svh
//////////////////////////////////////////////////
// ECC memory sizes and APB register map
//////////////////////////////////////////////////
`ifndef ECC_MEM_MACROS_SVH
`define ECC_MEM_MACROS_SVH

`define ECC_DATA_WIDTH  32
`define ECC_CODE_WIDTH  39  // 32 data + 6 Hamming + overall parity

// Data words are interleaved over the banks by the low word index bits
`define ECC_BANK_COUNT  4
`define ECC_BANK_DEPTH  16  // Words per bank

`define ECC_INJECT_ADDR 12'h800  // Fault injection register
`define ECC_COUNT_ADDR  12'h804  // Corrected read counter, read only

`endif

// File: rtl/eccPkg.sv
//////////////////////////////////////////////////
// SECDED codeword types, bank traffic and the
// encode and syndrome functions
//////////////////////////////////////////////////
`default_nettype none
`include "eccMem_macros.svh"

package eccPkg;

  localparam int HAMMING_WIDTH = `ECC_CODE_WIDTH - 1;  // Bits covered by the syndrome
  localparam int BANK_INDEX_WIDTH = $clog2(`ECC_BANK_DEPTH);

  typedef logic [`ECC_CODE_WIDTH-1:0] eccCodeword;
  typedef logic [6:0] eccSyndrome;  // Bit 6 is the overall parity, set when odd

  typedef struct packed {
    logic                        valid;
    logic                        write;
    logic [BANK_INDEX_WIDTH-1:0] index;
    eccCodeword                  codeword;
  } bankReq;

  typedef struct packed {
    logic       valid;
    eccCodeword codeword;
  } bankRsp;

  typedef struct packed {
    logic                       valid;
    logic [`ECC_DATA_WIDTH-1:0] data;
    logic                       corrected;
    logic                       uncorrectable;
  } eccReadResult;

  // Syndrome is the XOR of p+1 over every set bit p of the Hamming part
  function automatic eccSyndrome eccSyndromeOf(input eccCodeword code);
    logic [5:0] s;
    s = '0;
    for (int p = 0; p < HAMMING_WIDTH; p++)
    begin
      if (code[p])
        s = s ^ 6'(p + 1);
    end
    return {^code, s};
  endfunction

  function automatic eccCodeword eccEncode(input logic [`ECC_DATA_WIDTH-1:0] data);
    eccCodeword code;
    eccSyndrome syn;
    int         d;
    code = '0;
    d = 0;
    for (int p = 0; p < HAMMING_WIDTH; p++)
    begin
      if (((p + 1) & p) != 0)  // p+1 not a power of two, so a data slot
      begin
        code[p] = data[d];
        d++;
      end
    end
    // Check bits are set so that the syndrome of the whole word comes out zero
    syn = eccSyndromeOf(code);
    for (int k = 0; k < 6; k++)
      code[(1 << k) - 1] = syn[k];
    code[HAMMING_WIDTH] = ^code[HAMMING_WIDTH-1:0];
    return code;
  endfunction

endpackage

`default_nettype wire

// File: rtl/apbPkg.sv
//////////////////////////////////////////////////
// APB request and response bundles
//////////////////////////////////////////////////
`default_nettype none

package apbPkg;

  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  // Master to slave
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apbReq;

  // Slave to master
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apbRsp;

endpackage

`default_nettype wire

// File: rtl/apbEccFrontend.sv
//////////////////////////////////////////////////
// APB slave of the ECC memory, encodes writes,
// injects faults and routes bank requests
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "eccMem_macros.svh"

module apbEccFrontend
  import eccPkg::*;
  import apbPkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  apbReq        apbIn,
  output apbRsp        apbOut,
  output bankReq       bankReqs [`ECC_BANK_COUNT],
  input  eccReadResult readResult,
  input  logic [15:0]  correctedCount
);

  localparam int BANK_SEL_WIDTH = $clog2(`ECC_BANK_COUNT);

  logic                        access;
  logic                        isData;
  logic                        isInject;
  logic                        isCount;
  logic                        dataRead;
  logic                        dataWrite;
  logic                        readIssued;  // Bank read already sent for this transfer
  logic [5:0]                  injPosA;
  logic [5:0]                  injPosB;
  logic                        injEnA;
  logic                        injEnB;
  eccCodeword                  injMask;
  eccCodeword                  writeCode;
  logic [BANK_SEL_WIDTH-1:0]   bankSel;
  logic [BANK_INDEX_WIDTH-1:0] bankIndex;

  assign access    = apbIn.psel && apbIn.penable;
  assign isData    = apbIn.paddr[11:8] == 4'h0;  // 0x000 to 0x0FC
  assign isInject  = apbIn.paddr == `ECC_INJECT_ADDR;
  assign isCount   = apbIn.paddr == `ECC_COUNT_ADDR;
  assign dataRead  = access && isData && !apbIn.pwrite;
  assign dataWrite = access && isData && apbIn.pwrite;

  // Low word index bits pick the bank, the rest address inside it
  assign bankSel   = apbIn.paddr[2 +: BANK_SEL_WIDTH];
  assign bankIndex = apbIn.paddr[2 + BANK_SEL_WIDTH +: BANK_INDEX_WIDTH];

  always_comb
  begin
    injMask = '0;
    if (injEnA && injPosA < `ECC_CODE_WIDTH)
      injMask[injPosA] = 1'b1;
    if (injEnB && injPosB < `ECC_CODE_WIDTH)
      injMask[injPosB] = ~injMask[injPosB];  // Same position twice cancels out
  end

  assign writeCode = eccEncode(apbIn.pwdata) ^ injMask;

  always_comb
  begin
    for (int b = 0; b < `ECC_BANK_COUNT; b++)
    begin
      bankReqs[b].valid    = (dataWrite || (dataRead && !readIssued)) &&
                             bankSel == BANK_SEL_WIDTH'(b);
      bankReqs[b].write    = apbIn.pwrite;
      bankReqs[b].index    = bankIndex;
      bankReqs[b].codeword = writeCode;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      readIssued <= 1'b0;
    else if (apbOut.pready)
      readIssued <= 1'b0;
    else if (dataRead)
      readIssued <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      injPosA <= '0;
      injPosB <= '0;
      injEnA  <= 1'b0;
      injEnB  <= 1'b0;
    end
    else if (access && apbIn.pwrite && isInject)
    begin
      injPosA <= apbIn.pwdata[5:0];
      injEnA  <= apbIn.pwdata[6];
      injPosB <= apbIn.pwdata[13:8];
      injEnB  <= apbIn.pwdata[14];
    end
  end

  always_comb
  begin
    apbOut = '0;
    if (access)
    begin
      if (isData && !apbIn.pwrite)
      begin
        // Reads wait for the merge stage, two cycles after the bank request
        apbOut.pready  = readResult.valid;
        apbOut.pslverr = readResult.valid && readResult.uncorrectable;
        apbOut.prdata  = readResult.data;
      end
      else
      begin
        apbOut.pready  = 1'b1;
        apbOut.pslverr = !(isData || isInject || isCount);
        if (isInject)
          apbOut.prdata = {17'b0, injEnB, injPosB, 1'b0, injEnA, injPosA};
        else if (isCount)
          apbOut.prdata = {16'b0, correctedCount};
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    apbOut.pready |-> apbIn.psel && apbIn.penable)
    else $error("pready raised outside an APB access phase");

  // A merge result only ever answers a read this frontend sent out
  assert property (@(posedge clk) disable iff (reset)
    readResult.valid |-> dataRead && readIssued)
    else $error("Read result arrived without an outstanding read");

endmodule

`default_nettype wire

// File: rtl/eccBank.sv
//////////////////////////////////////////////////
// One bank of codeword storage, registered read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "eccMem_macros.svh"

module eccBank
  import eccPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  bankReq req,
  output bankRsp rsp
);

  eccCodeword mem [`ECC_BANK_DEPTH];
  eccCodeword readWord;
  logic       rspValid;
  logic       readReq;

  assign readReq = req.valid && !req.write;

  always_ff @(posedge clk)
  begin
    if (req.valid && req.write)
      mem[req.index] <= req.codeword;
  end

  // Read data only moves on a read so the output holds between accesses
  always_ff @(posedge clk)
  begin
    if (readReq)
      readWord <= mem[req.index];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rspValid <= 1'b0;
    else
      rspValid <= readReq;  // One cycle pulse per read
  end

  assign rsp = '{valid: rspValid, codeword: readWord};

  assert property (@(posedge clk) disable iff (reset)
    rsp.valid |-> $past(req.valid && !req.write))
    else $error("Bank response without a read in the previous cycle");

endmodule

`default_nettype wire

// File: rtl/eccReadMerge.sv
//////////////////////////////////////////////////
// Picks the returning bank word, checks and
// corrects it, counts corrected reads
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "eccMem_macros.svh"

module eccReadMerge
  import eccPkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  bankRsp       bankRsps [`ECC_BANK_COUNT],
  output eccReadResult result,
  output logic [15:0]  correctedCount
);

  logic [`ECC_BANK_COUNT-1:0] rspValid;
  logic                       anyValid;
  eccCodeword                 selWord;
  eccSyndrome                 syn;
  logic [5:0]                 flipPos;
  eccCodeword                 fixedWord;
  logic                       corrected;
  logic                       uncorrectable;
  logic [`ECC_DATA_WIDTH-1:0] fixedData;
  logic                       resultValid;
  logic [`ECC_DATA_WIDTH-1:0] resultData;
  logic                       resultCorrected;
  logic                       resultUncorr;

  // Pulls the data bits back out of the non power of two positions
  function automatic logic [`ECC_DATA_WIDTH-1:0] extractData(input eccCodeword code);
    logic [`ECC_DATA_WIDTH-1:0] data;
    int                         d;
    data = '0;
    d = 0;
    for (int p = 0; p < HAMMING_WIDTH; p++)
    begin
      if (((p + 1) & p) != 0)
      begin
        data[d] = code[p];
        d++;
      end
    end
    return data;
  endfunction

  always_comb
  begin
    selWord = '0;
    for (int b = 0; b < `ECC_BANK_COUNT; b++)
    begin
      rspValid[b] = bankRsps[b].valid;
      if (bankRsps[b].valid)
        selWord = selWord | bankRsps[b].codeword;
    end
  end

  assign anyValid = |rspValid;
  assign syn      = eccSyndromeOf(selWord);
  assign flipPos  = syn[5:0] - 6'd1;

  always_comb
  begin
    fixedWord     = selWord;
    corrected     = 1'b0;
    uncorrectable = 1'b0;
    if (syn[6])  // Odd parity means a single flip, unless the syndrome points off the word
    begin
      if (syn[5:0] == 6'd0)
        corrected = 1'b1;  // Only the parity bit itself was hit
      else if (syn[5:0] <= 6'(HAMMING_WIDTH))
      begin
        fixedWord[flipPos] = ~selWord[flipPos];
        corrected          = 1'b1;
      end
      else
        uncorrectable = 1'b1;
    end
    else if (syn[5:0] != 6'd0)
      uncorrectable = 1'b1;  // Even parity with a syndrome is a double error
  end

  assign fixedData = extractData(fixedWord);

  always_ff @(posedge clk)
  begin
    resultData      <= fixedData;
    resultCorrected <= corrected;
    resultUncorr    <= uncorrectable;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      resultValid    <= 1'b0;
      correctedCount <= '0;
    end
    else
    begin
      resultValid <= anyValid;
      if (anyValid && corrected && correctedCount != 16'hFFFF)
        correctedCount <= correctedCount + 16'd1;
    end
  end

  assign result = '{valid: resultValid, data: resultData,
                    corrected: resultCorrected, uncorrectable: resultUncorr};

  // Only one transfer is in flight, so no two banks answer together
  assert property (@(posedge clk) disable iff (reset) $onehot0(rspValid))
    else $error("More than one bank response valid");

endmodule

`default_nettype wire

// File: rtl/eccMemTop.sv
//////////////////////////////////////////////////
// ECC protected APB memory, frontend, interleaved
// banks and read merge
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "eccMem_macros.svh"

module eccMemTop
  import eccPkg::*;
  import apbPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  apbReq apbIn,
  output apbRsp apbOut
);

  bankReq       bankReqs [`ECC_BANK_COUNT];
  bankRsp       bankRsps [`ECC_BANK_COUNT];
  eccReadResult readResult;
  logic [15:0]  correctedCount;

  apbEccFrontend frontend_i (
    .clk            (clk),
    .reset          (reset),
    .apbIn          (apbIn),
    .apbOut         (apbOut),
    .bankReqs       (bankReqs),
    .readResult     (readResult),
    .correctedCount (correctedCount)
  );

  // One bank per low word index value
  for (genvar b = 0; b < `ECC_BANK_COUNT; b++)
  begin : genBank
    eccBank bank_i (
      .clk   (clk),
      .reset (reset),
      .req   (bankReqs[b]),
      .rsp   (bankRsps[b])
    );
  end

  eccReadMerge merge_i (
    .clk            (clk),
    .reset          (reset),
    .bankRsps       (bankRsps),
    .result         (readResult),
    .correctedCount (correctedCount)
  );

endmodule

`default_nettype wire

// File: verification/eccMemTb.sv
//////////////////////////////////////////////////
// Random APB testbench for the ECC memory with a
// memory model and its own SECDED model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "eccMem_macros.svh"

module eccMemTb
  import apbPkg::*;
();

  localparam int WORDS   = 64;
  localparam int TIMEOUT = 50;  // Access cycles allowed before giving up

  logic  clk;
  logic  reset;
  apbReq apbIn;
  apbRsp apbOut;

  integer      seed = 64;
  int          errors = 0;
  int          expectedCount = 0;
  logic [31:0] modelData [WORDS];
  logic [38:0] storedCode [WORDS];  // Codeword as the banks should hold it
  logic [38:0] injMask;

  eccMemTop eccMemTop_i (.clk(clk), .reset(reset), .apbIn(apbIn), .apbOut(apbOut));

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic isCheckPos(input int p);
    return p inside {0, 1, 3, 7, 15, 31};
  endfunction

  // Check bit k covers every position whose one-based number has bit k set
  function automatic logic [38:0] encodeModel(input logic [31:0] data);
    logic [38:0] code;
    int          d;
    code = '0;
    d = 0;
    for (int p = 0; p < 38; p++)
    begin
      if (!isCheckPos(p))
      begin
        code[p] = data[d];
        d++;
      end
    end
    for (int k = 0; k < 6; k++)
    begin
      for (int p = 0; p < 38; p++)
      begin
        if (!isCheckPos(p) && ((p + 1) >> k) % 2 == 1)
          code[(1 << k) - 1] ^= code[p];
      end
    end
    code[38] = ^code[37:0];
    return code;
  endfunction

  function automatic logic [5:0] syndromeModel(input logic [38:0] code);
    logic [5:0] s;
    s = '0;
    for (int k = 0; k < 6; k++)
    begin
      for (int p = 0; p < 38; p++)
      begin
        if (((p + 1) >> k) % 2 == 1)
          s[k] ^= code[p];
      end
    end
    return s;
  endfunction

  function automatic logic [31:0] extractModel(input logic [38:0] code);
    logic [31:0] data;
    int          d;
    data = '0;
    d = 0;
    for (int p = 0; p < 38; p++)
    begin
      if (!isCheckPos(p))
      begin
        data[d] = code[p];
        d++;
      end
    end
    return data;
  endfunction

  function automatic void predictRead(input logic [38:0] code, output logic [31:0] data,
                                      output logic err, output logic corr);
    logic [38:0] fixed;
    logic [5:0]  s;
    int          idx;
    fixed = code;
    s = syndromeModel(code);
    idx = s - 1;
    err = 1'b0;
    corr = 1'b0;
    if (^code && s == 0)
      corr = 1'b1;  // Only the parity bit flipped
    else if (^code && s <= 38)
    begin
      fixed[idx] = ~fixed[idx];
      corr = 1'b1;
    end
    else if (s != 0)
      err = 1'b1;  // Even parity with a syndrome or a syndrome past the word
    data = extractModel(fixed);
  endfunction

  function automatic logic [38:0] maskOf(input logic [31:0] value);
    logic [38:0] mask;
    mask = '0;
    if (value[6] && value[5:0] < 39)
      mask[value[5:0]] = 1'b1;
    if (value[14] && value[13:8] < 39)
      mask[value[13:8]] ^= 1'b1;
    return mask;
  endfunction

  function automatic logic [11:0] wordAddr(input int word);
    return {4'h0, 6'(word), 2'b00};
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    assert (got === expected)
    else
    begin
      $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      errors++;
    end
  endtask

  // Counts access cycles up to pready and samples the response at the falling edge
  task automatic awaitReady(output logic [31:0] rdata, output logic err, output int cycles);
    @(posedge clk);
    #1;
    apbIn.penable = 1'b1;
    cycles = 1;
    @(negedge clk);
    while (!apbOut.pready && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!apbOut.pready)
    begin
      $display("Timeout at %0t ns: no pready for address %0h", $time, apbIn.paddr);
      errors++;
    end
    rdata = apbOut.prdata;
    err = apbOut.pslverr;
    @(posedge clk);
    #1;
    apbIn = '0;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                          output logic err, output int cycles);
    logic [31:0] ignored;
    apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    awaitReady(ignored, err, cycles);
  endtask

  task automatic apbRead(input logic [11:0] addr, output logic [31:0] rdata,
                         output logic err, output int cycles);
    apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    awaitReady(rdata, err, cycles);
  endtask

  task automatic writeWord(input int word, input logic [31:0] data);
    logic err;
    int   cycles;
    apbWrite(wordAddr(word), data, err, cycles);
    checkValue(err, 0, "pslverr on data write");
    checkValue(cycles, 1, "access cycles of a data write");
    modelData[word] = data;
    storedCode[word] = encodeModel(data) ^ injMask;
  endtask

  task automatic readWord(input int word, output logic [31:0] rdata, output logic err);
    logic [31:0] expData;
    logic        expErr;
    logic        expCorr;
    int          cycles;
    predictRead(storedCode[word], expData, expErr, expCorr);
    apbRead(wordAddr(word), rdata, err, cycles);
    checkValue(rdata, expData, $sformatf("data of word %0d", word));
    checkValue(err, expErr, $sformatf("pslverr of word %0d", word));
    checkValue(cycles, 3, "access cycles of a data read");
    if (expCorr)
      expectedCount++;
  endtask

  task automatic writeInject(input logic [31:0] value);
    logic err;
    int   cycles;
    apbWrite(`ECC_INJECT_ADDR, value, err, cycles);
    checkValue(err, 0, "pslverr on injection write");
    checkValue(cycles, 1, "access cycles of a register write");
    injMask = maskOf(value);
  endtask

  task automatic readRegister(input logic [11:0] addr, input logic [31:0] expected,
                              input string what);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    apbRead(addr, rdata, err, cycles);
    checkValue(rdata, expected, what);
    checkValue(err, 0, {"pslverr on ", what});
    checkValue(cycles, 1, "access cycles of a register read");
  endtask

  task automatic accessUnmapped(input logic [11:0] addr, input logic write);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    if (write)
      apbWrite(addr, $random(seed), err, cycles);
    else
      apbRead(addr, rdata, err, cycles);
    checkValue(err, 1, $sformatf("pslverr at unmapped address %0h", addr));
    checkValue(cycles, 1, "access cycles at an unmapped address");
  endtask

  initial
  begin
    logic [31:0] value;
    logic [31:0] rdata;
    logic [11:0] addr;
    logic        err;
    int          cycles;
    int          word;
    int          posA;
    int          posB;
    apbIn = '0;
    reset = 1'b1;
    injMask = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Every word is written first so reads never see an empty slot
    for (int w = 0; w < WORDS; w++)
      writeWord(w, $random(seed));
    for (int i = 0; i < 200; i++)
    begin
      value = $random(seed);
      word = value[5:0];
      if (value[8])
        writeWord(word, $random(seed));
      else
        readWord(word, rdata, err);
    end
    readRegister(`ECC_COUNT_ADDR, expectedCount, "count after clean traffic");

    for (int i = 0; i < 12; i++)
    begin
      value = $random(seed);
      posA = (i == 0) ? 38 : value[15:0] % 39;  // First pass hits the parity bit
      word = value[21:16];
      writeInject(32'h40 | posA);
      writeWord(word, $random(seed));
      readWord(word, rdata, err);
      checkValue(rdata, modelData[word], "data after a single flip");
      readRegister(`ECC_COUNT_ADDR, expectedCount, "count after a single flip");
    end

    for (int i = 0; i < 8; i++)
    begin
      value = $random(seed);
      posA = value[15:0] % 39;
      posB = (posA + 1 + value[31:24] % 38) % 39;  // Never equal to posA
      word = value[21:16];
      writeInject(32'h4040 | (posB << 8) | posA);
      writeWord(word, $random(seed));
      readWord(word, rdata, err);
      checkValue(err, 1, "pslverr after a double flip");
      readRegister(`ECC_COUNT_ADDR, expectedCount, "count after a double flip");
    end

    value = $random(seed);
    writeInject(value);
    readRegister(`ECC_INJECT_ADDR, value & 32'h7F7F, "injection readback");
    writeInject(32'h0);
    readRegister(`ECC_INJECT_ADDR, 32'h0, "cleared injection register");
    for (int w = 0; w < WORDS; w++)
      writeWord(w, $random(seed));
    for (int w = 0; w < WORDS; w++)
    begin
      readWord(w, rdata, err);
      checkValue(rdata, modelData[w], "data after clearing injection");
    end

    // Every readable injection bit is set so a lost write shows in the readback
    writeInject(32'h7F7F);
    accessUnmapped(12'h100, 1'b1);
    accessUnmapped(12'h808, 1'b0);
    for (int i = 0; i < 16; i++)
    begin
      value = $random(seed);
      addr = value[11:0];
      if (addr[11:8] == 4'h0)
        addr[11:8] = 4'h9;
      if (addr == `ECC_INJECT_ADDR || addr == `ECC_COUNT_ADDR)
        addr = 12'hFFC;
      accessUnmapped(addr, value[12]);
    end
    apbWrite(`ECC_COUNT_ADDR, 32'hFFFF, err, cycles);
    checkValue(err, 0, "pslverr on counter write");
    readRegister(`ECC_COUNT_ADDR, expectedCount, "count after unmapped accesses");
    readRegister(`ECC_INJECT_ADDR, 32'h7F7F, "injection after unmapped accesses");
    for (int w = 0; w < WORDS; w++)
    begin
      readWord(w, rdata, err);
      checkValue(rdata, modelData[w], "data after unmapped accesses");
    end

    // Positions past the codeword are enabled but flip nothing
    for (int w = 0; w < 4; w++)
    begin
      writeWord(w, $random(seed));
      readWord(w, rdata, err);
      checkValue(rdata, modelData[w], "data with positions past the codeword");
    end

    $display("Checks done, %0d errors", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: eccMemTop.f
+incdir+rtl
rtl/eccPkg.sv
rtl/apbPkg.sv
rtl/apbEccFrontend.sv
rtl/eccBank.sv
rtl/eccReadMerge.sv
rtl/eccMemTop.sv
verification/eccMemTb.sv

// File: Bender.yml
package:
  name: eccMem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eccPkg.sv
      - rtl/apbPkg.sv
      - rtl/apbEccFrontend.sv
      - rtl/eccBank.sv
      - rtl/eccReadMerge.sv
      - rtl/eccMemTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/eccMemTb.sv
